/* rtl/vwalu_pkg.sv */
package vwalu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Lane geometry and instruction encodings
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned LANE_ELEMS = 4;      // Max wide results per slice.

    // OPMVV funct6 codes of the widening add/subtract group.
    localparam logic [5:0] FUNCT6_VWADDU  = 6'b110000;
    localparam logic [5:0] FUNCT6_VWADD   = 6'b110001;
    localparam logic [5:0] FUNCT6_VWSUBU  = 6'b110010;
    localparam logic [5:0] FUNCT6_VWSUB   = 6'b110011;
    localparam logic [5:0] FUNCT6_VWADDUW = 6'b110100;
    localparam logic [5:0] FUNCT6_VWADDW  = 6'b110101;
    localparam logic [5:0] FUNCT6_VWSUBUW = 6'b110110;
    localparam logic [5:0] FUNCT6_VWSUBW  = 6'b110111;

    typedef enum logic [3:0] {
        VW_NONE = 4'd0,                          // Illegal or idle.
        VWADDU  = 4'd1,
        VWADD   = 4'd2,
        VWSUBU  = 4'd3,
        VWSUB   = 4'd4,
        VWADDUW = 4'd5,                          // .w forms take a wide vs2.
        VWADDW  = 4'd6,
        VWSUBUW = 4'd7,
        VWSUBW  = 4'd8
    } vw_op_e;

    typedef enum logic [1:0] {
        SEW_8   = 2'b00,
        SEW_16  = 2'b01,
        SEW_32  = 2'b10,
        SEW_RSV = 2'b11                          // Treated as 32 bits.
    } sew_e;

    ////////////////////////////////////////////////////////////////////////////
    // Element views of the operand words
    ////////////////////////////////////////////////////////////////////////////

    // 64-bit slice, read as narrow or wide elements.
    typedef union packed {
        logic [7:0][7:0]  e8;
        logic [3:0][15:0] e16;
        logic [1:0][31:0] e32;
        logic [63:0]      w64;
    } vec64_u;

    // 32-bit vs1 slice, always narrow elements.
    typedef union packed {
        logic [3:0][7:0]  e8;
        logic [1:0][15:0] e16;
        logic [31:0]      w32;
    } vec32_u;

endpackage

/* rtl/vw_issue_if.sv */
`timescale 1ns/1ps

interface vw_issue_if;

    logic                               valid;     // Slice present.
    vwalu_pkg::vw_op_e                  op;        // Decoded operation.
    vwalu_pkg::sew_e                    sew;       // Narrow element width.
    logic                               illegal;   // Unknown funct6.
    vwalu_pkg::vec32_u                  vs1;       // Narrow operand.
    vwalu_pkg::vec64_u                  vs2;       // Narrow or wide operand.
    vwalu_pkg::vec64_u                  vd_old;    // Previous destination.
    logic [vwalu_pkg::LANE_ELEMS-1:0]   mask;      // Effective mask.

    modport issue (
        output valid, op, sew, illegal, vs1, vs2, vd_old, mask
    );

    modport alu (
        input op, sew, vs1, vs2
    );

    modport retire (
        input valid, sew, illegal, vd_old, mask
    );

endinterface

/* rtl/vw_issue_stage.sv */
`timescale 1ns/1ps

module vw_issue_stage (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                valid_i,
    input  logic [5:0]          funct6_i,
    input  logic [1:0]          sew_i,
    input  logic                vm_i,
    input  logic [3:0]          mask_i,
    input  logic [31:0]         vs1_i,
    input  logic [63:0]         vs2_i,
    input  logic [63:0]         vd_old_i,
    vw_issue_if.issue           issue_o
);

    vwalu_pkg::vw_op_e                  op_dec;
    logic                               illegal_dec;
    logic [vwalu_pkg::LANE_ELEMS-1:0]   mask_eff;

    ////////////////////////////////////////////////////////////////////////////
    // funct6 decode and effective mask
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        illegal_dec = 1'b0;
        case (funct6_i)
            vwalu_pkg::FUNCT6_VWADDU:  op_dec = vwalu_pkg::VWADDU;
            vwalu_pkg::FUNCT6_VWADD:   op_dec = vwalu_pkg::VWADD;
            vwalu_pkg::FUNCT6_VWSUBU:  op_dec = vwalu_pkg::VWSUBU;
            vwalu_pkg::FUNCT6_VWSUB:   op_dec = vwalu_pkg::VWSUB;
            vwalu_pkg::FUNCT6_VWADDUW: op_dec = vwalu_pkg::VWADDUW;
            vwalu_pkg::FUNCT6_VWADDW:  op_dec = vwalu_pkg::VWADDW;
            vwalu_pkg::FUNCT6_VWSUBUW: op_dec = vwalu_pkg::VWSUBUW;
            vwalu_pkg::FUNCT6_VWSUBW:  op_dec = vwalu_pkg::VWSUBW;
            default: begin
                op_dec      = vwalu_pkg::VW_NONE;    // Outside the group.
                illegal_dec = 1'b1;
            end
        endcase
    end

    // An illegal slice must not touch the destination at all.
    always_comb begin
        if (illegal_dec) begin
            mask_eff = '0;
        end else if (vm_i) begin
            mask_eff = '1;                           // Unmasked instruction.
        end else begin
            mask_eff = mask_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Slice register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            issue_o.valid   <= 1'b0;
            issue_o.op      <= vwalu_pkg::VW_NONE;
            issue_o.sew     <= vwalu_pkg::SEW_8;
            issue_o.illegal <= 1'b0;
        end else begin
            issue_o.valid <= valid_i;
            if (valid_i) begin
                issue_o.op      <= op_dec;
                issue_o.sew     <= vwalu_pkg::sew_e'(sew_i);
                issue_o.illegal <= illegal_dec;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            issue_o.mask   <= mask_eff;
            issue_o.vs1    <= vs1_i;
            issue_o.vs2    <= vs2_i;
            issue_o.vd_old <= vd_old_i;
        end
    end

endmodule

/* rtl/vwaddsub.sv */
`timescale 1ns/1ps

module vwaddsub (
    vw_issue_if.alu             issue_i,
    output vwalu_pkg::vec64_u   data_vd_o
);

    logic is_sgn;                                // Sign-extend operands.
    logic is_sub;                                // Subtract vs1.
    logic is_wide;                               // vs2 already 2*SEW wide.
    logic is_none;                               // No operation.

    ////////////////////////////////////////////////////////////////////////////
    // Operation flags
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        is_sgn  = 1'b0;
        is_sub  = 1'b0;
        is_wide = 1'b0;
        is_none = 1'b0;
        case (issue_i.op)
            vwalu_pkg::VWADDU: begin
                is_sgn = 1'b0;
            end
            vwalu_pkg::VWADD: begin
                is_sgn = 1'b1;
            end
            vwalu_pkg::VWSUBU: begin
                is_sub = 1'b1;
            end
            vwalu_pkg::VWSUB: begin
                is_sgn = 1'b1;
                is_sub = 1'b1;
            end
            vwalu_pkg::VWADDUW: begin
                is_wide = 1'b1;
            end
            vwalu_pkg::VWADDW: begin
                is_sgn  = 1'b1;
                is_wide = 1'b1;
            end
            vwalu_pkg::VWSUBUW: begin
                is_sub  = 1'b1;
                is_wide = 1'b1;
            end
            vwalu_pkg::VWSUBW: begin
                is_sgn  = 1'b1;
                is_sub  = 1'b1;
                is_wide = 1'b1;
            end
            default: is_none = 1'b1;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Widening add/subtract per element width
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        logic [15:0] a16, b16;
        logic [31:0] a32, b32;
        logic [63:0] a64, b64;
        data_vd_o = '0;
        a16       = '0;
        b16       = '0;
        a32       = '0;
        b32       = '0;
        a64       = '0;
        b64       = '0;
        if (!is_none) begin
            case (issue_i.sew)
                vwalu_pkg::SEW_8: begin
                    for (int i = 0; i < vwalu_pkg::LANE_ELEMS; i++) begin
                        a16 = is_wide ? issue_i.vs2.e16[i]
                                      : {{8{is_sgn & issue_i.vs2.e8[i][7]}}, issue_i.vs2.e8[i]};
                        b16 = {{8{is_sgn & issue_i.vs1.e8[i][7]}}, issue_i.vs1.e8[i]};
                        data_vd_o.e16[i] = is_sub ? a16 - b16 : a16 + b16;
                    end
                end
                vwalu_pkg::SEW_16: begin
                    for (int i = 0; i < 2; i++) begin
                        a32 = is_wide ? issue_i.vs2.e32[i]
                                      : {{16{is_sgn & issue_i.vs2.e16[i][15]}}, issue_i.vs2.e16[i]};
                        b32 = {{16{is_sgn & issue_i.vs1.e16[i][15]}}, issue_i.vs1.e16[i]};
                        data_vd_o.e32[i] = is_sub ? a32 - b32 : a32 + b32;
                    end
                end
                default: begin                   // SEW_32 and reserved.
                    a64 = is_wide ? issue_i.vs2.w64
                                  : {{32{is_sgn & issue_i.vs2.e32[0][31]}}, issue_i.vs2.e32[0]};
                    b64 = {{32{is_sgn & issue_i.vs1.w32[31]}}, issue_i.vs1.w32};
                    data_vd_o.w64 = is_sub ? a64 - b64 : a64 + b64;
                end
            endcase
        end
    end

endmodule

/* rtl/vw_retire_stage.sv */
`timescale 1ns/1ps

module vw_retire_stage (
    input  logic                clk_i,
    input  logic                rst_n_i,
    vw_issue_if.retire          issue_i,
    input  vwalu_pkg::vec64_u   data_vd_i,
    output logic                valid_o,
    output logic                illegal_o,
    output logic [63:0]         vd_o
);

    vwalu_pkg::vec64_u merged;

    ////////////////////////////////////////////////////////////////////////////
    // Mask-undisturbed merge at the wide element width
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        merged = issue_i.vd_old;                 // Start from old destination.
        case (issue_i.sew)
            vwalu_pkg::SEW_8: begin
                for (int k = 0; k < vwalu_pkg::LANE_ELEMS; k++) begin
                    if (issue_i.mask[k]) begin
                        merged.e16[k] = data_vd_i.e16[k];
                    end
                end
            end
            vwalu_pkg::SEW_16: begin
                for (int k = 0; k < 2; k++) begin
                    if (issue_i.mask[k]) begin
                        merged.e32[k] = data_vd_i.e32[k];
                    end
                end
            end
            default: begin
                // One 64-bit element, only mask bit 0 counts.
                if (issue_i.mask[0]) begin
                    merged.w64 = data_vd_i.w64;
                end
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o   <= 1'b0;
            illegal_o <= 1'b0;
            vd_o      <= '0;
        end else begin
            valid_o <= issue_i.valid;
            if (issue_i.valid) begin
                illegal_o <= issue_i.illegal;    // Passed through as decoded.
                vd_o      <= merged.w64;
            end
        end
    end

endmodule

/* rtl/vwalu_top.sv */
`timescale 1ns/1ps

module vwalu_top (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        valid_i,
    input  logic [5:0]  funct6_i,
    input  logic [1:0]  sew_i,
    input  logic        vm_i,
    input  logic [3:0]  mask_i,
    input  logic [31:0] vs1_i,
    input  logic [63:0] vs2_i,
    input  logic [63:0] vd_old_i,
    output logic        valid_o,
    output logic        illegal_o,
    output logic [63:0] vd_o
);

    vw_issue_if         issue_bus ();            // Registered slice.
    vwalu_pkg::vec64_u  raw_vd;                  // Unmerged results.

    ////////////////////////////////////////////////////////////////////////////
    // Issue, compute, retire
    ////////////////////////////////////////////////////////////////////////////

    vw_issue_stage u_issue (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .valid_i  (valid_i),
        .funct6_i (funct6_i),
        .sew_i    (sew_i),
        .vm_i     (vm_i),
        .mask_i   (mask_i),
        .vs1_i    (vs1_i),
        .vs2_i    (vs2_i),
        .vd_old_i (vd_old_i),
        .issue_o  (issue_bus.issue)
    );

    vwaddsub u_alu (
        .issue_i   (issue_bus.alu),
        .data_vd_o (raw_vd)
    );

    vw_retire_stage u_retire (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .issue_i   (issue_bus.retire),
        .data_vd_i (raw_vd),
        .valid_o   (valid_o),
        .illegal_o (illegal_o),
        .vd_o      (vd_o)
    );

endmodule

/* bench/vwalu_tb.sv */
`timescale 1ns/1ps

module vwalu_tb;

    localparam int NUM_SLICES  = 4000;
    localparam int DRAIN_LIMIT = 20;

    typedef struct packed {
        logic [31:0] due;                        // Cycle of the check.
        logic        valid;
        logic        full;                       // Check all outputs while idle.
        logic        illegal;
        logic [63:0] vd;
    } exp_t;

    logic        clk;
    logic        rst_n;
    logic        valid;
    logic [5:0]  funct6;
    logic [1:0]  sew;
    logic        vm;
    logic [3:0]  mask;
    logic [31:0] vs1;
    logic [63:0] vs2;
    logic [63:0] vd_old;
    logic        valid_out;
    logic        illegal_out;
    logic [63:0] vd_out;

    integer      seed;
    int          cyc;
    int          drain_cycles;
    exp_t        pending[$];                     // Expected results in order.

    vwalu_top uut (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .valid_i   (valid),
        .funct6_i  (funct6),
        .sew_i     (sew),
        .vm_i      (vm),
        .mask_i    (mask),
        .vs1_i     (vs1),
        .vs2_i     (vs2),
        .vd_old_i  (vd_old),
        .valid_o   (valid_out),
        .illegal_o (illegal_out),
        .vd_o      (vd_out)
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Low funct6 bits select signed, subtract and wide vs2.
    function automatic logic [63:0] model_vd(input logic [5:0]  f6,
                                             input logic [1:0]  sew_code,
                                             input logic        vm_bit,
                                             input logic [3:0]  mask_bits,
                                             input logic [31:0] vs1_w,
                                             input logic [63:0] vs2_w,
                                             input logic [63:0] old_w);
        int          nw;
        int          ww;
        int          n;
        logic [63:0] nm;
        logic [63:0] wm;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        logic [63:0] res;
        logic [3:0]  mbits;
        logic        legal;
        nw    = (sew_code == 2'b00) ? 8 : (sew_code == 2'b01) ? 16 : 32;
        ww    = 2 * nw;
        n     = 64 / ww;
        nm    = (64'd1 << nw) - 64'd1;
        wm    = (64'd1 << ww) - 64'd1;           // All ones for a 64-bit element.
        legal = (f6[5:3] == 3'b110);
        res   = old_w;
        for (int k = 0; k < n; k++) begin
            mbits = mask_bits >> k;
            if (legal && (vm_bit || mbits[0])) begin
                b = ({32'd0, vs1_w} >> (k * nw)) & nm;
                if (f6[0] && ((b & (64'd1 << (nw - 1))) != 64'd0)) begin
                    b = b | ~nm;
                end
                if (f6[2]) begin
                    a = (vs2_w >> (k * ww)) & wm;
                end else begin
                    a = (vs2_w >> (k * nw)) & nm;
                    if (f6[0] && ((a & (64'd1 << (nw - 1))) != 64'd0)) begin
                        a = a | ~nm;
                    end
                end
                r   = f6[1] ? a - b : a + b;
                res = (res & ~(wm << (k * ww))) | ((r & wm) << (k * ww));
            end
        end
        return res;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_run();
        $display(">>> FAIL");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        assert (got === want) else begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, want);
            stop_run();
        end
    endtask

    // Outputs are read at the falling edge, half a cycle after they change.
    task automatic next_cycle();
        @(negedge clk);
        cyc++;
    endtask

    task automatic compare_due_result();
        exp_t e;
        if (pending.size() > 0 && pending[0].due == cyc) begin
            e = pending.pop_front();
            check_value("valid_o", {63'd0, valid_out}, {63'd0, e.valid});
            if (e.valid || e.full) begin
                check_value("illegal_o", {63'd0, illegal_out}, {63'd0, e.illegal});
                check_value("vd_o", vd_out, e.vd);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_random_slice();
        logic [31:0] r;
        exp_t        e;
        r      = $random(seed);
        valid  = (r[1:0] != 2'd0);               // Random gaps between slices.
        funct6 = r[7:2];
        if (r[11:8] != 4'd0) begin
            funct6 = {3'b110, r[4:2]};
        end else if (funct6[5:3] == 3'b110) begin
            funct6 = funct6 ^ 6'b100000;         // Force it out of the group.
        end
        vm     = r[12] | r[13];
        sew    = r[15:14];                       // Code 11 included.
        mask   = r[19:16];
        vs1    = $random(seed);
        vs2    = {$random(seed), $random(seed)};
        vd_old = {$random(seed), $random(seed)};
        if (r[22:20] == 3'd0) begin
            vs1 = 32'hffff_ffff;                 // Deepest borrow.
            vs2 = 64'd0;
        end
        // Result shows two cycles after the slice is driven.
        e.due     = cyc + 2;
        e.valid   = valid;
        e.full    = 1'b0;
        e.illegal = (funct6[5:3] != 3'b110);
        e.vd      = model_vd(funct6, sew, vm, mask, vs1, vs2, vd_old);
        pending.push_back(e);
    endtask

    initial begin
        exp_t idle;
        seed           = 40357;
        clk            = 1'b0;
        rst_n          = 1'b0;
        valid          = 1'b0;
        funct6         = '0;
        sew            = '0;
        vm             = 1'b1;
        mask           = '0;
        vs1            = '0;
        vs2            = '0;
        vd_old         = '0;
        cyc            = 0;
        drain_cycles   = 0;

        repeat (3) begin
            next_cycle();
            check_value("valid_o", {63'd0, valid_out}, 64'd0);
            check_value("illegal_o", {63'd0, illegal_out}, 64'd0);
            check_value("vd_o", vd_out, 64'd0);
        end
        rst_n = 1'b1;

        // First cycle out of reset still shows the reset values.
        idle.due     = cyc + 1;
        idle.valid   = 1'b0;
        idle.full    = 1'b1;
        idle.illegal = 1'b0;
        idle.vd      = '0;
        pending.push_back(idle);
        drive_random_slice();

        repeat (NUM_SLICES - 1) begin
            next_cycle();
            compare_due_result();
            drive_random_slice();
        end

        while (pending.size() > 0 && drain_cycles < DRAIN_LIMIT) begin
            next_cycle();
            compare_due_result();
            valid = 1'b0;
            drain_cycles++;
        end

        if (pending.size() > 0) begin
            $display("Timeout: %0d results never reached the output.", pending.size());
            stop_run();
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

/* vwalu.f */
rtl/vwalu_pkg.sv
rtl/vw_issue_if.sv
rtl/vw_issue_stage.sv
rtl/vwaddsub.sv
rtl/vw_retire_stage.sv
rtl/vwalu_top.sv
bench/vwalu_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := vwalu_tb
FLIST     := vwalu.f
OBJ_DIR   := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard rtl/*.sv) $(wildcard bench/*.sv)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes.
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Exit status of the simulator is the pass or fail result.
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
